/* source/demux_bus_pkg.sv */
`default_nettype none

package demux_bus_pkg;

  // ********************
  // Bus widths
  // ********************
  localparam int unsigned addr_w = 32;
  localparam int unsigned data_w = 32;
  localparam int unsigned be_w   = data_w / 8;  // One enable per byte lane

  // ********************
  // Bus types
  // ********************
  typedef logic [addr_w-1:0] addr_t;
  typedef logic [data_w-1:0] data_t;
  typedef logic [be_w-1:0]   be_t;

  // Target of a core request
  typedef enum logic [1:0] {
    DEST_SH,   // Shared TCDM
    DEST_PE,   // Peripheral interconnect
    DEST_EXT   // Demux peripherals
  } dest_e;

endpackage

`default_nettype wire

/* source/demux_map_pkg.sv */
`default_nettype none

package demux_map_pkg;

  // ********************
  // Address fields
  // ********************
  localparam int unsigned region_msb = 31;
  localparam int unsigned region_lsb = 20;
  localparam int unsigned nibble_lsb = 28;  // Low bit of the swapped nibble
  localparam int unsigned ext_sel_bit = 14;  // EXT select inside DEM_PER

  typedef logic [region_msb-region_lsb:0] region_t;

  // Nibble exchanged with the cluster base
  localparam logic [3:0] cluster_nibble = 4'h1;

  // ********************
  // Cluster regions
  // ********************
  // Offsets from the region base of this cluster
  localparam int unsigned off_tcdm_rw = 0;
  localparam int unsigned off_tcdm_ts = 1;
  localparam int unsigned off_dem_per = 2;

  localparam int unsigned cluster_id_w = 6;
  localparam int unsigned base_w       = 4;

endpackage

`default_nettype wire

/* source/core_req_if.sv */
`default_nettype none

// One load/store request channel
interface core_req_if;

  logic                 req;
  demux_bus_pkg::addr_t add;
  logic                 wen;    // High for a load
  demux_bus_pkg::data_t wdata;
  demux_bus_pkg::be_t   be;
  logic                 gnt;

  modport master (
    output req,
    output add,
    output wen,
    output wdata,
    output be,
    input  gnt
  );

  modport slave (
    input  req,
    input  add,
    input  wen,
    input  wdata,
    input  be,
    output gnt
  );

endinterface

`default_nettype wire

/* source/addr_map_decoder.sv */
`default_nettype none

module addr_map_decoder (
  input  demux_bus_pkg::addr_t                   addr_i,
  input  logic [demux_map_pkg::base_w-1:0]       base_addr_i,
  input  logic [demux_map_pkg::cluster_id_w-1:0] cluster_id_i,
  output demux_bus_pkg::addr_t                   addr_o,
  output demux_bus_pkg::dest_e                   dest_o
);

  logic [demux_map_pkg::base_w-1:0] nibble_in;
  logic [demux_map_pkg::base_w-1:0] nibble_out;
  demux_map_pkg::region_t           region_base;
  demux_map_pkg::region_t           tcdm_rw;
  demux_map_pkg::region_t           tcdm_ts;
  demux_map_pkg::region_t           dem_per;
  demux_map_pkg::region_t           region;

  // ********************
  // Nibble swap
  // ********************
  assign nibble_in = addr_i[demux_bus_pkg::addr_w-1:demux_map_pkg::nibble_lsb];

  always_comb
  begin
    if (nibble_in == base_addr_i)
      nibble_out = demux_map_pkg::cluster_nibble;
    else if (nibble_in == demux_map_pkg::cluster_nibble)
      nibble_out = base_addr_i;
    else
      nibble_out = nibble_in;  // Outside the cluster, untouched
  end

  assign addr_o = {nibble_out, addr_i[demux_map_pkg::nibble_lsb-1:0]};

  // Each cluster owns four 1 MB regions above the base
  assign region_base = {base_addr_i, 8'h00} + demux_map_pkg::region_t'({cluster_id_i, 2'b00});
  assign tcdm_rw     = region_base + demux_map_pkg::region_t'(demux_map_pkg::off_tcdm_rw);
  assign tcdm_ts     = region_base + demux_map_pkg::region_t'(demux_map_pkg::off_tcdm_ts);
  assign dem_per     = region_base + demux_map_pkg::region_t'(demux_map_pkg::off_dem_per);

  assign region = addr_o[demux_map_pkg::region_msb:demux_map_pkg::region_lsb];

  // ********************
  // Destination
  // ********************
  always_comb
  begin
    if ((region == tcdm_rw) || (region == tcdm_ts))
      dest_o = demux_bus_pkg::DEST_SH;  // RW and test-and-set aliases of the TCDM
    else if ((region == dem_per) && addr_o[demux_map_pkg::ext_sel_bit])
      dest_o = demux_bus_pkg::DEST_EXT;
    else
      dest_o = demux_bus_pkg::DEST_PE;  // Cluster peripherals and the rest of the map
  end

endmodule

`default_nettype wire

/* source/pe_bridge.sv */
`default_nettype none

module pe_bridge (
  input  logic                 clk,
  input  logic                 rst_ni,

  core_req_if.slave            core_side,

  // Peripheral interconnect port
  output logic                 pe_req_o,
  input  logic                 pe_gnt_i,
  input  logic                 pe_r_valid_i,
  input  demux_bus_pkg::data_t pe_r_rdata_i,
  input  logic                 pe_r_opc_i,

  // Pipelined response towards the core
  output logic                 resp_valid_o,
  output demux_bus_pkg::data_t resp_rdata_o,
  output logic                 resp_opc_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PENDING,
    ST_GRANTED
  } state_e;

  state_e               state_q;
  state_e               state_d;
  logic                 valid_s0_q;
  demux_bus_pkg::data_t rdata_s0_q;
  logic                 opc_s0_q;

  // ********************
  // Transaction FSM
  // ********************
  always_ff @(posedge clk, negedge rst_ni)
  begin
    if (!rst_ni)
      state_q <= ST_IDLE;
    else
      state_q <= state_d;
  end

  always_comb
  begin
    state_d        = state_q;
    pe_req_o       = 1'b0;
    core_side.gnt  = 1'b0;

    case (state_q)
      ST_IDLE:
      begin
        pe_req_o = core_side.req;  // Held high under back-pressure
        if (core_side.req && pe_gnt_i)
          state_d = ST_PENDING;
      end

      ST_PENDING:
      begin
        // Wait for the interconnect to answer
        if (pe_r_valid_i)
          state_d = ST_GRANTED;
      end

      ST_GRANTED:
      begin
        core_side.gnt = 1'b1;  // Core sees the grant only once the answer is in
        state_d       = ST_IDLE;
      end

      default:
      begin
        state_d = ST_IDLE;
      end
    endcase
  end

  // ********************
  // Response pipeline
  // ********************
  // Stage 0 captures the answer, stage 1 lines it up after the core grant
  always_ff @(posedge clk, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      valid_s0_q   <= 1'b0;
      rdata_s0_q   <= '0;
      opc_s0_q     <= 1'b0;
      resp_valid_o <= 1'b0;
      resp_rdata_o <= '0;
      resp_opc_o   <= 1'b0;
    end
    else
    begin
      valid_s0_q   <= pe_r_valid_i;
      resp_valid_o <= valid_s0_q;
      if (pe_r_valid_i)
      begin
        rdata_s0_q <= pe_r_rdata_i;
        opc_s0_q   <= pe_r_opc_i;
      end
      if (valid_s0_q)
      begin
        resp_rdata_o <= rdata_s0_q;
        resp_opc_o   <= opc_s0_q;
      end
    end
  end

endmodule

`default_nettype wire

/* source/demux_ctrl.sv */
`default_nettype none

module demux_ctrl (
  input  logic                 clk,
  input  logic                 rst_ni,

  // Core side
  input  logic                 core_req_i,
  input  demux_bus_pkg::addr_t core_add_i,    // Already remapped
  input  logic                 core_wen_i,
  input  demux_bus_pkg::data_t core_wdata_i,
  input  demux_bus_pkg::be_t   core_be_i,
  output logic                 core_gnt_o,
  output logic                 core_r_valid_o,
  output demux_bus_pkg::data_t core_r_rdata_o,
  output logic                 core_r_opc_o,

  input  demux_bus_pkg::dest_e dest_i,

  // Shared TCDM
  output logic                 sh_req_o,
  input  logic                 sh_gnt_i,
  input  logic                 sh_r_valid_i,
  input  demux_bus_pkg::data_t sh_r_rdata_i,

  // Demux peripherals
  output logic                 ext_req_o,
  input  logic                 ext_gnt_i,
  input  logic                 ext_r_valid_i,
  input  demux_bus_pkg::data_t ext_r_rdata_i,
  input  logic                 ext_r_opc_i,

  // Peripheral interconnect through the bridge
  core_req_if.master           pe_req,
  input  logic                 pe_r_valid_i,
  input  demux_bus_pkg::data_t pe_r_rdata_i,
  input  logic                 pe_r_opc_i,

  output logic                 perf_l2_ld_o,
  output logic                 perf_l2_st_o,
  output logic                 perf_l2_ld_cyc_o,
  output logic                 perf_l2_st_cyc_o
);

  demux_bus_pkg::dest_e resp_dest_q;
  logic                 l2_req;
  logic                 l2_gnt;

  assign pe_req.add   = core_add_i;
  assign pe_req.wen   = core_wen_i;
  assign pe_req.wdata = core_wdata_i;
  assign pe_req.be    = core_be_i;

  // ********************
  // Request steering
  // ********************
  assign sh_req_o   = core_req_i && (dest_i == demux_bus_pkg::DEST_SH);
  assign ext_req_o  = core_req_i && (dest_i == demux_bus_pkg::DEST_EXT);
  assign pe_req.req = core_req_i && (dest_i == demux_bus_pkg::DEST_PE);

  always_comb
  begin
    case (dest_i)
      demux_bus_pkg::DEST_SH:  core_gnt_o = core_req_i && sh_gnt_i;
      demux_bus_pkg::DEST_EXT: core_gnt_o = core_req_i && ext_gnt_i;
      demux_bus_pkg::DEST_PE:  core_gnt_o = core_req_i && pe_req.gnt;
      default:                 core_gnt_o = 1'b0;
    endcase
  end

  // Remember where the last request went so the answer comes from there
  always_ff @(posedge clk, negedge rst_ni)
  begin
    if (!rst_ni)
      resp_dest_q <= demux_bus_pkg::DEST_SH;
    else if (core_req_i)
      resp_dest_q <= dest_i;
  end

  // ********************
  // Response select
  // ********************
  always_comb
  begin
    case (resp_dest_q)
      demux_bus_pkg::DEST_PE:
      begin
        core_r_valid_o = pe_r_valid_i;
        core_r_rdata_o = pe_r_rdata_i;
        core_r_opc_o   = pe_r_opc_i;
      end
      demux_bus_pkg::DEST_EXT:
      begin
        core_r_valid_o = ext_r_valid_i;
        core_r_rdata_o = ext_r_rdata_i;
        core_r_opc_o   = ext_r_opc_i;
      end
      default:
      begin
        core_r_valid_o = sh_r_valid_i;
        core_r_rdata_o = sh_r_rdata_i;
        core_r_opc_o   = 1'b0;  // TCDM never reports an error
      end
    endcase
  end

  // L2 means anything beyond the TCDM
  assign l2_req = ext_req_o || pe_req.req;
  assign l2_gnt = (ext_req_o && ext_gnt_i) || (pe_req.req && pe_req.gnt);

  assign perf_l2_ld_o     = l2_gnt && core_wen_i;
  assign perf_l2_st_o     = l2_gnt && !core_wen_i;
  assign perf_l2_ld_cyc_o = l2_req && core_wen_i;   // Counts stall cycles too
  assign perf_l2_st_cyc_o = l2_req && !core_wen_i;

endmodule

`default_nettype wire

/* source/periph_demux_top.sv */
`default_nettype none

module periph_demux_top (
  input  logic                 clk,
  input  logic                 rst_ni,
  input  logic [3:0]           base_addr_i,
  input  logic [5:0]           cluster_id_i,

  // Core
  input  logic                 data_req_i,
  input  demux_bus_pkg::addr_t data_add_i,
  input  logic                 data_wen_i,
  input  demux_bus_pkg::data_t data_wdata_i,
  input  demux_bus_pkg::be_t   data_be_i,
  output logic                 data_gnt_o,
  output logic                 data_r_valid_o,
  output demux_bus_pkg::data_t data_r_rdata_o,
  output logic                 data_r_opc_o,

  // Shared TCDM
  output logic                 sh_req_o,
  output demux_bus_pkg::addr_t sh_add_o,
  output logic                 sh_wen_o,
  output demux_bus_pkg::data_t sh_wdata_o,
  output demux_bus_pkg::be_t   sh_be_o,
  input  logic                 sh_gnt_i,
  input  logic                 sh_r_valid_i,
  input  demux_bus_pkg::data_t sh_r_rdata_i,

  // Demux peripherals
  output logic                 ext_req_o,
  output demux_bus_pkg::addr_t ext_add_o,
  output logic                 ext_wen_o,
  output demux_bus_pkg::data_t ext_wdata_o,
  output demux_bus_pkg::be_t   ext_be_o,
  input  logic                 ext_gnt_i,
  input  logic                 ext_r_valid_i,
  input  demux_bus_pkg::data_t ext_r_rdata_i,
  input  logic                 ext_r_opc_i,

  // Peripheral interconnect
  output logic                 pe_req_o,
  output demux_bus_pkg::addr_t pe_add_o,
  output logic                 pe_wen_o,
  output demux_bus_pkg::data_t pe_wdata_o,
  output demux_bus_pkg::be_t   pe_be_o,
  input  logic                 pe_gnt_i,
  input  logic                 pe_r_valid_i,
  input  demux_bus_pkg::data_t pe_r_rdata_i,
  input  logic                 pe_r_opc_i,

  output logic                 perf_l2_ld_o,
  output logic                 perf_l2_st_o,
  output logic                 perf_l2_ld_cyc_o,
  output logic                 perf_l2_st_cyc_o
);

  demux_bus_pkg::addr_t add_remap;
  demux_bus_pkg::dest_e dest;
  logic                 pe_resp_valid;
  demux_bus_pkg::data_t pe_resp_rdata;
  logic                 pe_resp_opc;

  core_req_if pe_req ();

  addr_map_decoder u_decoder (
    .addr_i       ( data_add_i   ),
    .base_addr_i  ( base_addr_i  ),
    .cluster_id_i ( cluster_id_i ),
    .addr_o       ( add_remap    ),
    .dest_o       ( dest         )
  );

  demux_ctrl u_ctrl (
    .clk              ( clk              ),
    .rst_ni           ( rst_ni           ),
    .core_req_i       ( data_req_i       ),
    .core_add_i       ( add_remap        ),
    .core_wen_i       ( data_wen_i       ),
    .core_wdata_i     ( data_wdata_i     ),
    .core_be_i        ( data_be_i        ),
    .core_gnt_o       ( data_gnt_o       ),
    .core_r_valid_o   ( data_r_valid_o   ),
    .core_r_rdata_o   ( data_r_rdata_o   ),
    .core_r_opc_o     ( data_r_opc_o     ),
    .dest_i           ( dest             ),
    .sh_req_o         ( sh_req_o         ),
    .sh_gnt_i         ( sh_gnt_i         ),
    .sh_r_valid_i     ( sh_r_valid_i     ),
    .sh_r_rdata_i     ( sh_r_rdata_i     ),
    .ext_req_o        ( ext_req_o        ),
    .ext_gnt_i        ( ext_gnt_i        ),
    .ext_r_valid_i    ( ext_r_valid_i    ),
    .ext_r_rdata_i    ( ext_r_rdata_i    ),
    .ext_r_opc_i      ( ext_r_opc_i      ),
    .pe_req           ( pe_req.master    ),
    .pe_r_valid_i     ( pe_resp_valid    ),
    .pe_r_rdata_i     ( pe_resp_rdata    ),
    .pe_r_opc_i       ( pe_resp_opc      ),
    .perf_l2_ld_o     ( perf_l2_ld_o     ),
    .perf_l2_st_o     ( perf_l2_st_o     ),
    .perf_l2_ld_cyc_o ( perf_l2_ld_cyc_o ),
    .perf_l2_st_cyc_o ( perf_l2_st_cyc_o )
  );

  pe_bridge u_pe_bridge (
    .clk          ( clk           ),
    .rst_ni       ( rst_ni        ),
    .core_side    ( pe_req.slave  ),
    .pe_req_o     ( pe_req_o      ),
    .pe_gnt_i     ( pe_gnt_i      ),
    .pe_r_valid_i ( pe_r_valid_i  ),
    .pe_r_rdata_i ( pe_r_rdata_i  ),
    .pe_r_opc_i   ( pe_r_opc_i    ),
    .resp_valid_o ( pe_resp_valid ),
    .resp_rdata_o ( pe_resp_rdata ),
    .resp_opc_o   ( pe_resp_opc   )
  );

  // ********************
  // Payload fan-out
  // ********************
  assign sh_add_o    = add_remap;
  assign sh_wen_o    = data_wen_i;
  assign sh_wdata_o  = data_wdata_i;
  assign sh_be_o     = data_be_i;

  assign ext_add_o   = add_remap;
  assign ext_wen_o   = data_wen_i;
  assign ext_wdata_o = data_wdata_i;
  assign ext_be_o    = data_be_i;

  // PE payload as carried by the bridge channel
  assign pe_add_o    = pe_req.add;
  assign pe_wen_o    = pe_req.wen;
  assign pe_wdata_o  = pe_req.wdata;
  assign pe_be_o     = pe_req.be;

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 100ps;

  // 20 ns period
  always #10 clk_o = ~clk_o;

  initial
  begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    #2;
    rst_no = 1'b1;  // Released just after the third edge
  end

endmodule

`default_nettype wire

/* dv/tb_periph_demux.sv */
`default_nettype none

module tb_periph_demux;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int wait_limit = 40;

  logic clk;
  logic rst_ni;
  logic [3:0] base_addr;
  logic [5:0] cluster_id;
  logic data_req_i, data_wen_i, data_gnt_o, data_r_valid_o, data_r_opc_o;
  logic [31:0] data_add_i, data_wdata_i, data_r_rdata_o;
  logic [3:0] data_be_i, sh_be_o, ext_be_o, pe_be_o;
  logic sh_req_o, sh_wen_o, sh_gnt_i, sh_r_valid_i;
  logic ext_req_o, ext_wen_o, ext_gnt_i, ext_r_valid_i, ext_r_opc_i;
  logic pe_req_o, pe_wen_o, pe_gnt_i, pe_r_valid_i, pe_r_opc_i;
  logic [31:0] sh_add_o, sh_wdata_o, sh_r_rdata_i;
  logic [31:0] ext_add_o, ext_wdata_o, ext_r_rdata_i;
  logic [31:0] pe_add_o, pe_wdata_o, pe_r_rdata_i;
  logic perf_l2_ld_o, perf_l2_st_o, perf_l2_ld_cyc_o, perf_l2_st_cyc_o;

  int checks;
  int errors;
  int last_pe_stall;
  logic [31:0] lfsr_state;

  // Target model state and knobs
  logic sh_hit, ext_hit, pe_hit;
  logic [31:0] sh_addr, ext_addr, pe_addr;
  int ext_wait, ext_gnt_dly, pe_wait, pe_gnt_dly, pe_rsp_dly, pe_cnt;
  logic ext_opc_cfg, pe_opc_cfg;

  tb_clk_gen u_clk_gen (
    .clk_o  ( clk    ),
    .rst_no ( rst_ni )
  );

  periph_demux_top u_dut (
    .clk (clk), .rst_ni (rst_ni), .base_addr_i (base_addr), .cluster_id_i (cluster_id),
    .data_req_i (data_req_i), .data_add_i (data_add_i), .data_wen_i (data_wen_i),
    .data_wdata_i (data_wdata_i), .data_be_i (data_be_i), .data_gnt_o (data_gnt_o),
    .data_r_valid_o (data_r_valid_o), .data_r_rdata_o (data_r_rdata_o),
    .data_r_opc_o (data_r_opc_o),
    .sh_req_o (sh_req_o), .sh_add_o (sh_add_o), .sh_wen_o (sh_wen_o),
    .sh_wdata_o (sh_wdata_o), .sh_be_o (sh_be_o), .sh_gnt_i (sh_gnt_i),
    .sh_r_valid_i (sh_r_valid_i), .sh_r_rdata_i (sh_r_rdata_i),
    .ext_req_o (ext_req_o), .ext_add_o (ext_add_o), .ext_wen_o (ext_wen_o),
    .ext_wdata_o (ext_wdata_o), .ext_be_o (ext_be_o), .ext_gnt_i (ext_gnt_i),
    .ext_r_valid_i (ext_r_valid_i), .ext_r_rdata_i (ext_r_rdata_i),
    .ext_r_opc_i (ext_r_opc_i),
    .pe_req_o (pe_req_o), .pe_add_o (pe_add_o), .pe_wen_o (pe_wen_o),
    .pe_wdata_o (pe_wdata_o), .pe_be_o (pe_be_o), .pe_gnt_i (pe_gnt_i),
    .pe_r_valid_i (pe_r_valid_i), .pe_r_rdata_i (pe_r_rdata_i), .pe_r_opc_i (pe_r_opc_i),
    .perf_l2_ld_o (perf_l2_ld_o), .perf_l2_st_o (perf_l2_st_o),
    .perf_l2_ld_cyc_o (perf_l2_ld_cyc_o), .perf_l2_st_cyc_o (perf_l2_st_cyc_o)
  );

  // ********************
  // Reference rules
  // ********************
  function automatic logic [31:0] remap_addr(input logic [31:0] a, input logic [3:0] base);
    logic [3:0] nib;
    nib = a[31:demux_map_pkg::nibble_lsb];
    if (nib == base)
      nib = demux_map_pkg::cluster_nibble;
    else if (nib == demux_map_pkg::cluster_nibble)
      nib = base;
    return {nib, a[demux_map_pkg::nibble_lsb-1:0]};
  endfunction

  function automatic demux_bus_pkg::dest_e expect_dest(input logic [31:0] a,
                                                       input logic [3:0] base,
                                                       input logic [5:0] cid);
    logic [31:0] r;
    logic [11:0] region;
    logic [11:0] cl_base;
    r       = remap_addr(a, base);
    region  = r[demux_map_pkg::region_msb:demux_map_pkg::region_lsb];
    cl_base = {base, 8'h00} + {4'h0, cid, 2'b00};
    if (region[11:1] == cl_base[11:1])
      return demux_bus_pkg::DEST_SH;  // TCDM RW or test-and-set
    if ((region == cl_base + 12'(demux_map_pkg::off_dem_per)) && r[demux_map_pkg::ext_sel_bit])
      return demux_bus_pkg::DEST_EXT;
    return demux_bus_pkg::DEST_PE;
  endfunction

  // Read data returned by each target for an address
  function automatic logic [31:0] sh_data(input logic [31:0] a);
    return {a[15:0], a[31:16]} ^ 32'h5a5a_a5a5;
  endfunction

  function automatic logic [31:0] ext_data(input logic [31:0] a);
    return ~a;
  endfunction

  function automatic logic [31:0] pe_data(input logic [31:0] a);
    return a + 32'h1234_5678;
  endfunction

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // ********************
  // Target models
  // ********************
  assign sh_gnt_i = sh_req_o;  // SH grants at once

  always @(posedge clk)
  begin
    sh_hit  = sh_req_o && sh_gnt_i;
    sh_addr = sh_add_o;
    #1;
    sh_r_valid_i = sh_hit;
    sh_r_rdata_i = sh_hit ? sh_data(sh_addr) : '0;
  end

  always @(posedge clk)
  begin
    ext_hit = ext_req_o && ext_gnt_i;
    if (ext_hit || !ext_req_o)
      ext_wait = 0;
    else
      ext_wait = ext_wait + 1;
    if (ext_hit)
      ext_addr = ext_add_o;
    #1;
    ext_gnt_i     = (ext_wait != 0) && (ext_wait >= ext_gnt_dly);
    ext_r_valid_i = ext_hit;
    ext_r_rdata_i = ext_hit ? ext_data(ext_addr) : '0;
    ext_r_opc_i   = ext_hit && ext_opc_cfg;
  end

  always @(posedge clk)
  begin
    pe_hit = pe_req_o && pe_gnt_i;
    if (pe_hit || !pe_req_o)
      pe_wait = 0;
    else
      pe_wait = pe_wait + 1;
    if (pe_hit)
    begin
      pe_cnt  = pe_rsp_dly + 1;  // Answer pe_rsp_dly cycles after the accept
      pe_addr = pe_add_o;
    end
    else if (pe_cnt > 0)
      pe_cnt = pe_cnt - 1;
    #1;
    pe_gnt_i     = (pe_wait != 0) && (pe_wait >= pe_gnt_dly);
    pe_r_valid_i = (pe_cnt == 1);
    pe_r_rdata_i = (pe_cnt == 1) ? pe_data(pe_addr) : '0;
    pe_r_opc_i   = (pe_cnt == 1) && pe_opc_cfg;
  end

  // ********************
  // Checks and reporting
  // ********************
  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("MISMATCH %s: expected %h, actual %h", what, exp, act);
    end
  endtask

  task automatic report_and_finish();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  endtask

  task automatic abort_run(input string msg);
    errors++;
    $display("ERROR: %s", msg);
    report_and_finish();
  endtask

  task automatic release_req();
    @(posedge clk);
    #2;
    data_req_i = 1'b0;
  endtask

  task automatic complete_sh(input string name, input logic [31:0] radd);
    check_val({name, " gnt follows sh_gnt_i"}, sh_gnt_i, data_gnt_o);
    check_val({name, " gnt"}, 1, data_gnt_o);
    check_val({name, " perf"}, 0,
              {perf_l2_ld_o, perf_l2_st_o, perf_l2_ld_cyc_o, perf_l2_st_cyc_o});
    release_req();
    @(negedge clk);
    check_val({name, " r_valid"}, 1, data_r_valid_o);
    check_val({name, " rdata"}, sh_data(radd), data_r_rdata_o);
    check_val({name, " opc"}, 0, data_r_opc_o);
  endtask

  task automatic await_ext(input string name, input logic [31:0] radd, input logic wen);
    int cyc;
    cyc = 0;
    while (!data_gnt_o)
    begin
      check_val({name, " perf cyc"}, {wen, !wen}, {perf_l2_ld_cyc_o, perf_l2_st_cyc_o});
      check_val({name, " perf early"}, 0, {perf_l2_ld_o, perf_l2_st_o});
      cyc++;
      if (cyc > wait_limit)
        abort_run({"no grant from the EXT port in ", name});
      @(negedge clk);
    end
    check_val({name, " perf gnt"}, {wen, !wen}, {perf_l2_ld_o, perf_l2_st_o});
    release_req();
    cyc = 0;
    @(negedge clk);
    while (!data_r_valid_o)
    begin
      cyc++;
      if (cyc > wait_limit)
        abort_run({"no EXT response in ", name});
      @(negedge clk);
    end
    check_val({name, " rdata"}, ext_data(radd), data_r_rdata_o);
    check_val({name, " opc"}, ext_opc_cfg, data_r_opc_o);
  endtask

  task automatic pe_handshake(input string name, input logic [31:0] radd, input logic wen);
    int cyc;
    int stall;
    stall = 0;
    while (!pe_gnt_i)
    begin
      check_val({name, " pe_req_o held"}, 1, pe_req_o);
      check_val({name, " gnt while stalled"}, 0, data_gnt_o);
      stall++;
      if (stall > wait_limit)
        abort_run({"no grant from the PE port in ", name});
      @(negedge clk);
    end
    last_pe_stall = stall;
    cyc = 0;
    @(negedge clk);
    while (!pe_r_valid_i)
    begin
      check_val({name, " pe_req_o pending"}, 0, pe_req_o);
      check_val({name, " gnt pending"}, 0, data_gnt_o);
      cyc++;
      if (cyc > wait_limit)
        abort_run({"no PE response in ", name});
      @(negedge clk);
    end
    check_val({name, " pe_req_o pending"}, 0, pe_req_o);
    check_val({name, " gnt at pe r_valid"}, 0, data_gnt_o);
    @(negedge clk);
    check_val({name, " gnt after pe r_valid"}, 1, data_gnt_o);
    check_val({name, " early r_valid"}, 0, data_r_valid_o);
    check_val({name, " perf gnt"}, {wen, !wen}, {perf_l2_ld_o, perf_l2_st_o});
    release_req();
    @(negedge clk);
    check_val({name, " r_valid"}, 1, data_r_valid_o);
    check_val({name, " rdata"}, pe_data(radd), data_r_rdata_o);
    check_val({name, " opc"}, pe_opc_cfg, data_r_opc_o);
  endtask

  // One full access, routed by the reference map
  task automatic run_access(input string name, input logic [31:0] addr, input logic wen);
    demux_bus_pkg::dest_e dest;
    logic [31:0] radd;
    logic [3:0] be;
    dest = expect_dest(addr, base_addr, cluster_id);
    radd = remap_addr(addr, base_addr);
    be   = addr[7:4] ^ addr[3:0] ^ 4'h9;  // Byte lanes vary with the address
    @(posedge clk);
    #2;
    data_req_i   = 1'b1;
    data_add_i   = addr;
    data_wen_i   = wen;
    data_wdata_i = ~addr;
    data_be_i    = be;
    @(negedge clk);
    check_val({name, " sh_req_o"}, dest == demux_bus_pkg::DEST_SH, sh_req_o);
    check_val({name, " ext_req_o"}, dest == demux_bus_pkg::DEST_EXT, ext_req_o);
    check_val({name, " pe_req_o"}, dest == demux_bus_pkg::DEST_PE, pe_req_o);
    check_val({name, " sh_add_o"}, radd, sh_add_o);
    check_val({name, " ext_add_o"}, radd, ext_add_o);
    check_val({name, " pe_add_o"}, radd, pe_add_o);
    check_val({name, " sh_wdata_o"}, ~addr, sh_wdata_o);
    check_val({name, " ext_wdata_o"}, ~addr, ext_wdata_o);
    check_val({name, " pe_wdata_o"}, ~addr, pe_wdata_o);
    check_val({name, " wen"}, {3{wen}}, {sh_wen_o, ext_wen_o, pe_wen_o});
    check_val({name, " be"}, {3{be}}, {sh_be_o, ext_be_o, pe_be_o});
    case (dest)
      demux_bus_pkg::DEST_SH:  complete_sh(name, radd);
      demux_bus_pkg::DEST_EXT: await_ext(name, radd, wen);
      default:                 pe_handshake(name, radd, wen);
    endcase
  endtask

  task automatic set_base(input logic [3:0] base);
    @(posedge clk);
    #2;
    base_addr = base;
  endtask

  // ********************
  // Directed tests
  // ********************
  task automatic remap_and_sh();
    pe_gnt_dly = 0;
    pe_rsp_dly = 0;
    run_access("remap nibble 0", 32'h0010_0040, 1'b1);  // Outside the cluster
    run_access("remap base 1", 32'h1010_0040, 1'b1);
    set_base(4'h2);
    run_access("remap base 2", 32'h2000_0000, 1'b1);  // Swapped to 0x1000_0000
    run_access("remap base 2 sh", 32'h1000_0080, 1'b1);
    set_base(4'h1);
  endtask

  task automatic ext_routing();
    ext_gnt_dly = 3;
    ext_opc_cfg = 1'b1;
    run_access("ext load", 32'h1020_4010, 1'b1);
    ext_opc_cfg = 1'b0;
    run_access("ext store", 32'h1020_4020, 1'b0);
    run_access("dem_per without sel", 32'h1020_0010, 1'b1);
  endtask

  task automatic pe_timing();
    pe_gnt_dly = 1;
    pe_rsp_dly = 3;
    pe_opc_cfg = 1'b1;
    run_access("pe load", 32'h1030_0100, 1'b1);
    pe_rsp_dly = 0;
    pe_opc_cfg = 1'b0;
    run_access("pe store", 32'h1030_0104, 1'b0);
  endtask

  task automatic pe_backpressure();
    pe_gnt_dly = 4;
    pe_rsp_dly = 1;
    run_access("pe stall", 32'h0800_0000, 1'b1);
    check_val("pe stall cycles", 4, last_pe_stall);
  endtask

  task automatic random_decode();
    logic [31:0] r;
    logic [31:0] addr;
    pe_gnt_dly  = 0;
    pe_rsp_dly  = 1;
    ext_gnt_dly = 1;
    for (int n = 0; n < 32; n++)
    begin
      draw_bits(24, r);
      // Keep most draws near the cluster regions
      addr = {2'b00, r[23:22], 6'd0, r[21:20], r[19:0]};
      draw_bits(1, r);
      run_access($sformatf("random %0d", n), addr, r[0]);
    end
  endtask

  initial
  begin
    int cyc;
    checks = 0;
    errors = 0;
    lfsr_state = 32'had37_de43;
    base_addr = 4'h1;
    cluster_id = 6'd0;
    data_req_i = 1'b0;
    data_add_i = '0;
    data_wen_i = 1'b0;
    data_wdata_i = '0;
    data_be_i = '0;
    sh_r_valid_i = 1'b0;
    sh_r_rdata_i = '0;
    ext_gnt_i = 1'b0;
    ext_r_valid_i = 1'b0;
    ext_r_rdata_i = '0;
    ext_r_opc_i = 1'b0;
    pe_gnt_i = 1'b0;
    pe_r_valid_i = 1'b0;
    pe_r_rdata_i = '0;
    pe_r_opc_i = 1'b0;
    ext_wait = 0;
    pe_wait = 0;
    pe_cnt = 0;
    ext_gnt_dly = 1;
    pe_gnt_dly = 0;
    pe_rsp_dly = 0;
    ext_opc_cfg = 1'b0;
    pe_opc_cfg = 1'b0;
    last_pe_stall = 0;
    cyc = 0;
    while (rst_ni !== 1'b1)
    begin
      cyc++;
      if (cyc > wait_limit)
        abort_run("reset was never released");
      @(posedge clk);
    end
    remap_and_sh();
    ext_routing();
    pe_timing();
    pe_backpressure();
    random_decode();
    report_and_finish();
  end

endmodule

`default_nettype wire

/* files.f */
source/demux_bus_pkg.sv
source/demux_map_pkg.sv
source/core_req_if.sv
source/addr_map_decoder.sv
source/pe_bridge.sv
source/demux_ctrl.sv
source/periph_demux_top.sv
dv/tb_clk_gen.sv
dv/tb_periph_demux.sv

/* Bender.yml */
package:
  name: periph_demux

sources:
  - source/demux_bus_pkg.sv
  - source/demux_map_pkg.sv
  - source/core_req_if.sv
  - source/addr_map_decoder.sv
  - source/pe_bridge.sv
  - source/demux_ctrl.sv
  - source/periph_demux_top.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_periph_demux.sv
